// File: source/uart_cmd_macros.svh
`ifndef UART_CMD_MACROS_SVH
`define UART_CMD_MACROS_SVH

// Serial timing, in clock cycles.
`define UCB_BIT_CYCLES   16
`define UCB_GAP_CYCLES   40
`define UCB_REPLY_CYCLES 400

// Width of the shared timer counter.
`define UCB_TMR_W        16

// Register offsets on the APB port.
`define UCB_REG_CMD      4'h0
`define UCB_REG_STATUS   4'h4
`define UCB_REG_RDATA    4'h8

`endif

// File: source/uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  // **************************************************
  // Host side
  // **************************************************
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // **************************************************
  // Serial transaction
  // **************************************************
  // Bit 15 is the direction, 1 means write.
  typedef struct packed {
    logic       rw;
    logic [6:0] addr;
    logic [7:0] wdata;
  } uart_cmd_t;

  typedef struct packed {
    logic       done;
    logic [7:0] rdata;
    logic       parity_err;
    logic       timeout;
  } uart_result_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_HEAD,
    SEND_DATA,
    GAP,
    WAIT_REPLY,
    RECV_REPLY,
    FINISH
  } seq_state_t;

  // Timer load modes.
  localparam logic [1:0] TMR_BIT   = 2'd0;
  localparam logic [1:0] TMR_HALF  = 2'd1;
  localparam logic [1:0] TMR_GAP   = 2'd2;
  localparam logic [1:0] TMR_REPLY = 2'd3;

endpackage

`default_nettype wire

// File: source/apb_cmd_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_macros.svh"

module apb_cmd_regs (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire uart_cmd_pkg::apb_req_t  apb_req,
  output uart_cmd_pkg::apb_rsp_t       apb_rsp,
  input  wire                          busy,
  input  wire uart_cmd_pkg::uart_result_t result,
  output uart_cmd_pkg::uart_cmd_t      cmd,
  output logic                         cmd_start
);

  logic                    access;
  logic                    wr_en;
  logic                    rd_en;
  logic                    hit_cmd;
  logic                    hit_status;
  logic                    hit_rdata;
  uart_cmd_pkg::uart_cmd_t cmd_q;
  logic [7:0]              rdata_q;
  logic                    rd_valid;
  logic                    parity_err;
  logic                    timeout;
  logic                    good_reply;

  assign access     = apb_req.psel && apb_req.penable;
  assign wr_en      = access && apb_req.pwrite;
  assign rd_en      = access && !apb_req.pwrite;
  assign hit_cmd    = (apb_req.paddr == `UCB_REG_CMD);
  assign hit_status = (apb_req.paddr == `UCB_REG_STATUS);
  assign hit_rdata  = (apb_req.paddr == `UCB_REG_RDATA);

  assign cmd_start  = wr_en && hit_cmd && !busy;
  assign cmd        = cmd_q;
  assign good_reply = result.done && !cmd_q.rw && !result.parity_err && !result.timeout;

  always_comb
  begin
    apb_rsp.prdata  = '0;
    apb_rsp.pready  = 1'b1;
    // Unmapped offset, or a new command while the link is busy.
    apb_rsp.pslverr = access && ((!hit_cmd && !hit_status && !hit_rdata) ||
                                 (hit_cmd && apb_req.pwrite && busy));
    if (rd_en)
    begin
      if (hit_cmd)
        apb_rsp.prdata[15:0] = cmd_q;
      else if (hit_status)
        apb_rsp.prdata[3:0] = {timeout, parity_err, rd_valid, busy};
      else if (hit_rdata)
        apb_rsp.prdata[7:0] = rdata_q;
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_start)
      cmd_q <= uart_cmd_pkg::uart_cmd_t'(apb_req.pwdata[15:0]);
    if (good_reply)
      rdata_q <= result.rdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_valid   <= 1'b0;
      parity_err <= 1'b0;
      timeout    <= 1'b0;
    end
    else if (cmd_start)
    begin
      rd_valid   <= 1'b0;
      parity_err <= 1'b0;
      timeout    <= 1'b0;
    end
    else if (result.done)
    begin
      rd_valid   <= good_reply;
      parity_err <= result.parity_err;
      timeout    <= result.timeout;
    end
    else if (rd_en && hit_rdata)
      rd_valid <= 1'b0;
  end

  // An accepted command makes the sequencer busy from the next edge.
  a_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_start |=> busy);

endmodule

`default_nettype wire

// File: source/cmd_seq_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_seq_fsm (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire uart_cmd_pkg::uart_cmd_t cmd,
  input  wire                      cmd_start,
  output logic                     busy,
  output uart_cmd_pkg::uart_result_t result,
  output logic                     tx_load,
  output logic [7:0]               tx_byte,
  input  wire                      tx_done,
  output logic                     rx_arm,
  input  wire                      rx_start_seen,
  input  wire                      rx_done,
  input  wire [7:0]                rx_byte,
  input  wire                      rx_parity_fail,
  output logic                     tmr_start,
  output logic [1:0]               tmr_mode,
  input  wire                      tick
);

  uart_cmd_pkg::seq_state_t state;
  logic [7:0]               rdata_q;
  logic                     perr_q;
  logic                     tmo_q;

  assign busy    = (state != uart_cmd_pkg::IDLE);
  // Head byte carries the direction in its top bit.
  assign tx_byte = (state == uart_cmd_pkg::SEND_DATA) ? cmd.wdata : {cmd.rw, cmd.addr};

  always_comb
  begin
    result.done       = (state == uart_cmd_pkg::FINISH);
    result.rdata      = rdata_q;
    result.parity_err = perr_q;
    result.timeout    = tmo_q;
  end

  // **************************************************
  // Sequencer
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= uart_cmd_pkg::IDLE;
      tx_load   <= 1'b0;
      tmr_start <= 1'b0;
      tmr_mode  <= uart_cmd_pkg::TMR_BIT;
      rx_arm    <= 1'b0;
      perr_q    <= 1'b0;
      tmo_q     <= 1'b0;
    end
    else
    begin
      tx_load   <= 1'b0;
      tmr_start <= 1'b0;
      case (state)
        uart_cmd_pkg::IDLE:
          if (cmd_start)
          begin
            state     <= uart_cmd_pkg::SEND_HEAD;
            tx_load   <= 1'b1;
            tmr_start <= 1'b1;
            tmr_mode  <= uart_cmd_pkg::TMR_BIT;
            perr_q    <= 1'b0;
            tmo_q     <= 1'b0;
          end
        uart_cmd_pkg::SEND_HEAD:
          if (tx_done)
          begin
            state     <= uart_cmd_pkg::GAP;
            tmr_start <= 1'b1;
            tmr_mode  <= uart_cmd_pkg::TMR_GAP;
            // Reads listen from here, a fast peer may answer inside the gap.
            rx_arm    <= !cmd.rw;
          end
        uart_cmd_pkg::GAP, uart_cmd_pkg::WAIT_REPLY:
          if (rx_start_seen)
          begin
            state     <= uart_cmd_pkg::RECV_REPLY;
            rx_arm    <= 1'b0;
            tmr_start <= 1'b1;
            tmr_mode  <= uart_cmd_pkg::TMR_HALF;
          end
          else if (tick && state == uart_cmd_pkg::WAIT_REPLY)
          begin
            state  <= uart_cmd_pkg::FINISH;
            rx_arm <= 1'b0;
            tmo_q  <= 1'b1;
          end
          else if (tick)
          begin
            state     <= cmd.rw ? uart_cmd_pkg::SEND_DATA : uart_cmd_pkg::WAIT_REPLY;
            tx_load   <= cmd.rw;
            tmr_start <= 1'b1;
            tmr_mode  <= cmd.rw ? uart_cmd_pkg::TMR_BIT : uart_cmd_pkg::TMR_REPLY;
          end
        uart_cmd_pkg::RECV_REPLY:
          if (rx_done)
          begin
            state  <= uart_cmd_pkg::FINISH;
            perr_q <= rx_parity_fail;
          end
        uart_cmd_pkg::SEND_DATA:
          if (tx_done)
            state <= uart_cmd_pkg::FINISH;
        default:
          state <= uart_cmd_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == uart_cmd_pkg::RECV_REPLY && rx_done)
      rdata_q <= rx_byte;
  end

  // Frames are launched only on entry to a send state.
  a_load_in_send: assert property (@(posedge clk) disable iff (!rst_n)
    tx_load |-> (state == uart_cmd_pkg::SEND_HEAD || state == uart_cmd_pkg::SEND_DATA));

  // The register block offers a command only while the sequencer is idle.
  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_start |-> (state == uart_cmd_pkg::IDLE));

endmodule

`default_nettype wire

// File: source/baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_macros.svh"

module baud_timer (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       tmr_start,
  input  wire [1:0] tmr_mode,
  output logic      tick
);

  localparam int CW = `UCB_TMR_W;

  logic [CW-1:0] cnt;
  logic [CW-1:0] load_val;
  logic          active;
  logic          periodic;

  always_comb
  begin
    case (tmr_mode)
      uart_cmd_pkg::TMR_HALF:  load_val = CW'(`UCB_BIT_CYCLES / 2 - 1);
      uart_cmd_pkg::TMR_GAP:   load_val = CW'(`UCB_GAP_CYCLES - 1);
      uart_cmd_pkg::TMR_REPLY: load_val = CW'(`UCB_REPLY_CYCLES - 1);
      default:                 load_val = CW'(`UCB_BIT_CYCLES - 1);
    endcase
  end

  // A restart cancels a tick due in the same cycle.
  assign tick = active && (cnt == '0) && !tmr_start;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt      <= '0;
      active   <= 1'b0;
      periodic <= 1'b0;
    end
    else if (tmr_start)
    begin
      cnt      <= load_val;
      active   <= 1'b1;
      periodic <= (tmr_mode == uart_cmd_pkg::TMR_BIT) || (tmr_mode == uart_cmd_pkg::TMR_HALF);
    end
    else if (active)
    begin
      if (cnt != '0)
        cnt <= cnt - 1'b1;
      else if (periodic)
        cnt <= CW'(`UCB_BIT_CYCLES - 1);
      else
        active <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/uart_tx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       tx_load,
  input  wire [7:0] tx_byte,
  input  wire       tick,
  output logic      tx,
  output logic      tx_done
);

  logic [10:0] shift_q;
  logic [3:0]  bit_cnt;
  logic        shifting;

  // Line idles high, so the register refills with ones.
  assign tx = shift_q[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shift_q  <= '1;
      bit_cnt  <= '0;
      shifting <= 1'b0;
      tx_done  <= 1'b0;
    end
    else
    begin
      tx_done <= 1'b0;
      if (tx_load)
      begin
        // Stop, odd parity, data, start.
        shift_q  <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
        bit_cnt  <= '0;
        shifting <= 1'b1;
      end
      else if (shifting && tick)
      begin
        if (bit_cnt == 4'd10)
        begin
          shift_q  <= '1;
          shifting <= 1'b0;
          tx_done  <= 1'b1;
        end
        else
        begin
          shift_q <= {1'b1, shift_q[10:1]};
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // The sequencer waits for tx_done before the next frame.
  a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    tx_load |-> !shifting);

endmodule

`default_nettype wire

// File: source/uart_rx_frame.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        rx,
  input  wire        rx_arm,
  input  wire        tick,
  output logic       rx_start_seen,
  output logic       rx_done,
  output logic [7:0] rx_byte,
  output logic       rx_parity_fail
);

  logic [2:0] sync_q;
  logic       rx_s;
  logic       receiving;
  logic [3:0] bit_idx;
  logic [7:0] data_q;
  logic       par_q;

  // Oldest stage in bit 2.
  assign rx_s          = sync_q[1];
  assign rx_start_seen = rx_arm && sync_q[2] && !sync_q[1];
  assign rx_byte       = data_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sync_q <= 3'b111;
    else
      sync_q <= {sync_q[1:0], rx};
  end

  // **************************************************
  // Sampling, one sample per tick from mid start bit.
  // **************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      receiving      <= 1'b0;
      bit_idx        <= '0;
      rx_done        <= 1'b0;
      rx_parity_fail <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (rx_start_seen)
      begin
        receiving <= 1'b1;
        bit_idx   <= '0;
      end
      else if (receiving && tick)
      begin
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == 4'd10)
        begin
          receiving      <= 1'b0;
          rx_done        <= 1'b1;
          rx_parity_fail <= ~^{par_q, data_q};
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (receiving && tick)
    begin
      if (bit_idx >= 4'd1 && bit_idx <= 4'd8)
        data_q <= {rx_s, data_q[7:1]};
      else if (bit_idx == 4'd9)
        par_q <= rx_s;
    end
  end

endmodule

`default_nettype wire

// File: source/uart_cmd_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire uart_cmd_pkg::apb_req_t apb_req,
  output uart_cmd_pkg::apb_rsp_t      apb_rsp,
  input  wire                         rx,
  output logic                        tx
);

  uart_cmd_pkg::uart_cmd_t    cmd;
  uart_cmd_pkg::uart_result_t result;
  logic                       cmd_start;
  logic                       busy;
  logic                       tx_load;
  logic [7:0]                 tx_byte;
  logic                       tx_done;
  logic                       rx_arm;
  logic                       rx_start_seen;
  logic                       rx_done;
  logic [7:0]                 rx_byte;
  logic                       rx_parity_fail;
  logic                       tmr_start;
  logic [1:0]                 tmr_mode;
  logic                       tick;

  apb_cmd_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .busy      (busy),
    .result    (result),
    .cmd       (cmd),
    .cmd_start (cmd_start)
  );

  cmd_seq_fsm u_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd            (cmd),
    .cmd_start      (cmd_start),
    .busy           (busy),
    .result         (result),
    .tx_load        (tx_load),
    .tx_byte        (tx_byte),
    .tx_done        (tx_done),
    .rx_arm         (rx_arm),
    .rx_start_seen  (rx_start_seen),
    .rx_done        (rx_done),
    .rx_byte        (rx_byte),
    .rx_parity_fail (rx_parity_fail),
    .tmr_start      (tmr_start),
    .tmr_mode       (tmr_mode),
    .tick           (tick)
  );

  baud_timer u_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .tmr_start (tmr_start),
    .tmr_mode  (tmr_mode),
    .tick      (tick)
  );

  uart_tx_frame u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_load (tx_load),
    .tx_byte (tx_byte),
    .tick    (tick),
    .tx      (tx),
    .tx_done (tx_done)
  );

  uart_rx_frame u_rx (
    .clk            (clk),
    .rst_n          (rst_n),
    .rx             (rx),
    .rx_arm         (rx_arm),
    .tick           (tick),
    .rx_start_seen  (rx_start_seen),
    .rx_done        (rx_done),
    .rx_byte        (rx_byte),
    .rx_parity_fail (rx_parity_fail)
  );

endmodule

`default_nettype wire

// File: dv/uart_peer_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_macros.svh"

module uart_peer_model (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        tx,
  input  wire [7:0]  reply_byte,
  input  wire [1:0]  reply_mode,
  output logic       rx,
  output logic       ready,
  output int         frame_cnt,
  output int         req_perr,
  output int         frame_err
);

  logic [7:0] byte_log [0:255];

  // Waits for a start bit on tx, then samples every bit at its middle.
  task automatic recv_frame(output logic [7:0] b, output logic par_ok, output logic frm_ok);
    logic [7:0] data;
    logic       par;
    data = '0;
    @(negedge clk);
    while (tx)
      @(negedge clk);
    ready = 1'b0;
    repeat (`UCB_BIT_CYCLES / 2) @(negedge clk);
    frm_ok = (tx == 1'b0);
    for (int i = 0; i < 8; i++)
    begin
      repeat (`UCB_BIT_CYCLES) @(negedge clk);
      data = {tx, data[7:1]};
    end
    repeat (`UCB_BIT_CYCLES) @(negedge clk);
    par = tx;
    repeat (`UCB_BIT_CYCLES) @(negedge clk);
    frm_ok = frm_ok && (tx == 1'b1);
    b      = data;
    par_ok = ^{par, data};
  endtask

  task automatic send_frame(input logic [7:0] b, input logic bad_par);
    logic [10:0] f;
    f = {1'b1, (bad_par ? ^b : ~^b), b, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx = f[0];
      f  = {1'b1, f[10:1]};
      repeat (`UCB_BIT_CYCLES) @(negedge clk);
    end
  endtask

  initial
  begin
    logic [7:0] b;
    logic       par_ok;
    logic       frm_ok;
    logic       expect_data;
    int         delay_bits;
    void'($urandom(71));
    rx          = 1'b1;
    ready       = 1'b0;
    frame_cnt   = 0;
    req_perr    = 0;
    frame_err   = 0;
    expect_data = 1'b0;
    wait (rst_n);
    forever
    begin
      ready = 1'b1;
      recv_frame(b, par_ok, frm_ok);
      byte_log[frame_cnt[7:0]] = b;
      frame_cnt = frame_cnt + 1;
      if (!par_ok)
        req_perr = req_perr + 1;
      if (!frm_ok)
        frame_err = frame_err + 1;
      if (expect_data)
        expect_data = 1'b0;
      else if (b[7])
        expect_data = 1'b1;
      else if (reply_mode != 2'd2)
      begin
        // Read request answered after a random pause.
        delay_bits = int'($urandom % 8) + 1;
        repeat (delay_bits * `UCB_BIT_CYCLES) @(negedge clk);
        send_frame(reply_byte, reply_mode == 2'd1);
      end
    end
  end

endmodule

`default_nettype wire

// File: dv/uart_cmd_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_macros.svh"

module uart_cmd_bridge_tb;

  logic                   clk;
  logic                   rst_n;
  uart_cmd_pkg::apb_req_t apb_req;
  uart_cmd_pkg::apb_rsp_t apb_rsp;
  wire                    tx;
  wire                    rx;
  wire                    peer_ready;
  logic [7:0]             reply_byte;
  logic [1:0]             reply_mode;
  int                     frame_cnt;
  int                     req_perr;
  int                     frame_err;
  int                     err_cnt;
  int                     n_tests;

  logic [7:0] kinds [$];
  logic [6:0] addrs [$];
  logic [7:0] wdatas [$];
  logic [7:0] replies [$];
  logic [1:0] modes [$];

  uart_cmd_bridge DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .rx      (rx),
    .tx      (tx)
  );

  uart_peer_model peer (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx         (tx),
    .reply_byte (reply_byte),
    .reply_mode (reply_mode),
    .rx         (rx),
    .ready      (peer_ready),
    .frame_cnt  (frame_cnt),
    .req_perr   (req_perr),
    .frame_err  (frame_err)
  );

  always #4 clk = ~clk;

  // **************************************************
  // Host side tasks
  // **************************************************
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic slverr);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #2;
    slverr = apb_rsp.pslverr;
    check_value("pready", {31'h0, apb_rsp.pready}, 32'h1);
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic slverr);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #2;
    data   = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_value("pready", {31'h0, apb_rsp.pready}, 32'h1);
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
      err_cnt = err_cnt + 1;
    end
  endtask

  // Polls STATUS until the busy bit drops.
  task automatic wait_idle();
    logic [31:0] st;
    logic        se;
    st = 32'h1;
    while (st[0])
      apb_read(`UCB_REG_STATUS, st, se);
  endtask

  task automatic load_tests();
    int          fd;
    int          cnt;
    string       line;
    logic [7:0]  k;
    logic [31:0] a;
    logic [31:0] w;
    logic [31:0] r;
    logic [31:0] m;
    fd = $fopen("dv/uart_cmd_tests.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the test file dv/uart_cmd_tests.txt");
      err_cnt = err_cnt + 1;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        cnt = $sscanf(line, "%c %h %h %h %h", k, a, w, r, m);
        if (cnt == 5 && k != 8'h23)
        begin
          kinds.push_back(k);
          addrs.push_back(a[6:0]);
          wdatas.push_back(w[7:0]);
          replies.push_back(r[7:0]);
          modes.push_back(m[1:0]);
        end
      end
      $fclose(fd);
    end
    n_tests = kinds.size();
  endtask

  task automatic run_test(input int i);
    logic [15:0] cmd;
    logic [31:0] data;
    logic        se;
    logic        is_read;
    logic [7:0]  idx;
    int          base;
    is_read    = (kinds[i] == "R");
    reply_byte = replies[i];
    reply_mode = modes[i];
    while (!peer_ready)
      @(negedge clk);
    base = frame_cnt;
    cmd  = {!is_read, addrs[i], wdatas[i]};
    apb_write(`UCB_REG_CMD, {16'h0, cmd}, se);
    check_value("pslverr", {31'h0, se}, 32'h0);
    if (kinds[i] == "E")
    begin
      apb_write(`UCB_REG_CMD, {16'h0, cmd ^ 16'h00ff}, se);
      check_value("pslverr", {31'h0, se}, 32'h1);
      apb_read(4'hc, data, se);
      check_value("pslverr", {31'h0, se}, 32'h1);
      check_value("prdata", data, 32'h0);
      apb_write(4'h2, 32'h1, se);
      check_value("pslverr", {31'h0, se}, 32'h1);
    end
    wait_idle();
    apb_read(`UCB_REG_STATUS, data, se);
    idx = base[7:0];
    if (!is_read)
    begin
      check_value("frames", frame_cnt - base, 2);
      check_value("head_byte", {24'h0, peer.byte_log[idx]}, {24'h0, 1'b1, addrs[i]});
      idx = idx + 8'd1;
      check_value("data_byte", {24'h0, peer.byte_log[idx]}, {24'h0, wdatas[i]});
      check_value("status", data, 32'h0);
    end
    else
    begin
      check_value("frames", frame_cnt - base, 1);
      check_value("head_byte", {24'h0, peer.byte_log[idx]}, {24'h0, 1'b0, addrs[i]});
      if (modes[i] == 2'd0)
      begin
        check_value("status", data, 32'h2);
        apb_read(`UCB_REG_RDATA, data, se);
        check_value("rdata", data, {24'h0, replies[i]});
        apb_read(`UCB_REG_STATUS, data, se);
        check_value("status", data, 32'h0);
      end
      else if (modes[i] == 2'd1)
        check_value("status", data, 32'h4);
      else
        check_value("status", data, 32'h8);
    end
  endtask

  // Watchdog sized from the number of tests.
  initial
  begin
    longint limit;
    wait (n_tests > 0);
    limit = longint'(n_tests) * (3 * 11 * `UCB_BIT_CYCLES + 2 * `UCB_GAP_CYCLES +
            `UCB_REPLY_CYCLES) * 8 * 2;
    #(limit);
    $display("Timeout: the tests did not finish within %0d ns", limit);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    logic [31:0] data;
    logic        se;
    clk        = 1'b0;
    rst_n      = 1'b0;
    apb_req    = '0;
    reply_byte = '0;
    reply_mode = 2'd2;
    err_cnt    = 0;
    n_tests    = 0;
    load_tests();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    if (n_tests == 0)
    begin
      $display("No tests were found in the test file");
      err_cnt = err_cnt + 1;
    end
    else
    begin
      check_value("tx", {31'h0, tx}, 32'h1);
      apb_read(`UCB_REG_STATUS, data, se);
      check_value("status", data, 32'h0);
      for (int i = 0; i < n_tests; i++)
        run_test(i);
      check_value("req_perr", req_perr, 0);
      check_value("frame_err", frame_err, 0);
    end
    $display("Errors: %0d over %0d tests", err_cnt, n_tests);
    if (err_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/uart_cmd_tests.txt
# kind addr(hex) wdata(hex) reply(hex) mode
# kind W write, R read, E write with error probes; mode 0 good, 1 bad parity, 2 silent
W 12 a5 00 0
R 12 00 3c 0
W 7f ff 00 0
R 00 00 81 0
R 45 00 5a 1
R 33 00 00 2
E 21 0f 00 0
W 00 00 00 0
R 7f 00 ff 0
R 01 00 00 1
E 55 7e 00 0
R 2a 00 c3 0
W 40 80 00 0
R 6b 00 00 2
R 19 00 e7 0
W 0a 5a 00 0

// File: uart_cmd_bridge.f
+incdir+source
source/uart_cmd_pkg.sv
source/apb_cmd_regs.sv
source/cmd_seq_fsm.sv
source/baud_timer.sv
source/uart_tx_frame.sv
source/uart_rx_frame.sv
source/uart_cmd_bridge.sv
dv/uart_peer_model.sv
dv/uart_cmd_bridge_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the bridge testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f uart_cmd_bridge.f \
  --top-module uart_cmd_bridge_tb -o uart_cmd_bridge_sim
./obj_dir/uart_cmd_bridge_sim > sim.log
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
  exit 1
fi
exit 0
